/* Makefile */
# Verilator build of the config space testbench

VERILATOR ?= verilator
TOP       ?= tb_cfg_space
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_cfg_space.sv */
`timescale 1ns/1ps

module tb_cfg_space import cfg_pkg::*; ();

  localparam logic [31:0] BAR0_RST = 32'hE000_0000, BAR0_MSK = 32'hFFFF_F000;
  localparam logic [31:0] BAR1_RST = 32'hE100_0000, BAR1_MSK = 32'hFFF0_0000;
  localparam logic [31:0] BAR2_RST = 32'hE200_0000, BAR2_MSK = 32'hFFFF_FF00;
  localparam logic [15:0] VEN_ID = 16'h1A2B, DEV_ID = 16'h7001;
  localparam logic [15:0] SUB_VEN_ID = 16'h1A2B, SUB_ID = 16'h0042;
  localparam logic [23:0] CLASS = 24'h0B4000;
  localparam logic [7:0]  CLINE = 8'h10;
  localparam logic [15:0] STAT_EXP = 16'h0001 << 5 | 16'h0001 << 7 | 16'h0001 << 9;
  localparam int          APB_TIMEOUT = 10;

  logic        clk, rst;
  logic        psel, penable, pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata, prdata;
  logic [3:0]  pstrb;
  logic        pready, pslverr;
  logic        bus_cyc;
  logic [31:0] bus_adr;
  logic [2:0]  cs_bar;
  logic [3:0]  irq;
  logic        msg_valid, msg_ready;
  logic [12:0] msg_tid;
  logic [31:0] msg_adr, msg_dat;

  logic [31:0] bar_msk [3];
  logic [31:0] bar_m [3];    // expected BAR contents
  int          errors, checks, tests, tests_bad, err_mark;

  tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(5)) u_clkgen (.clk_o(clk), .rst_o(rst));

  cfg_space_top #(
    .NIRQ(4), .FIFO_DEPTH(32),
    .BAR0_RESET(BAR0_RST), .BAR1_RESET(BAR1_RST), .BAR2_RESET(BAR2_RST),
    .BAR0_MASK(BAR0_MSK), .BAR1_MASK(BAR1_MSK), .BAR2_MASK(BAR2_MSK),
    .VENDOR_ID(VEN_ID), .DEVICE_ID(DEV_ID), .SUBSYS_VENDOR_ID(SUB_VEN_ID),
    .SUBSYS_ID(SUB_ID), .CLASS_CODE(CLASS), .CACHE_LINE(CLINE)
  ) uut (
    .clk_i(clk), .rst_i(rst), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb), .prdata_o(prdata),
    .pready_o(pready), .pslverr_o(pslverr), .bus_cyc_i(bus_cyc), .bus_adr_i(bus_adr),
    .cs_bar_o(cs_bar), .irq_i(irq), .msg_valid_o(msg_valid), .msg_ready_i(msg_ready),
    .msg_tid_o(msg_tid), .msg_adr_o(msg_adr), .msg_dat_o(msg_dat)
  );

  // ==========================================================
  // checks and bookkeeping
  // ==========================================================
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, want, got);
    end
  endtask

  task automatic check_cond(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR at %0t ns: %s did not hold", $time, what);
    end
  endtask

  task automatic test_begin();
    err_mark = errors;
  endtask

  task automatic test_end(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    end
  endtask

  // ==========================================================
  // apb master with setup then access until pready
  // ==========================================================
  task automatic apb_xfer(input logic wr, input logic [9:0] off, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata, output logic err);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= {off, 2'b00};  // word offset to byte address
    pwdata  <= wdata;
    pstrb   <= strb;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!pready && waited < APB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    check_cond("pready_o within the apb timeout", pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [9:0] off, input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] unused_rd;
    logic        err;
    apb_xfer(1'b1, off, data, strb, unused_rd, err);
    check_val("pslverr_o on write", 32'(err), 32'd0);
  endtask

  task automatic apb_read(input logic [9:0] off, output logic [31:0] rdata, output logic err);
    apb_xfer(1'b0, off, 32'd0, 4'h0, rdata, err);
  endtask

  // polls msg_valid_o at falling edges and gives up after limit cycles
  task automatic wait_msg(input int limit, output logic seen);
    int n;
    n = 0;
    @(negedge clk);
    while (!msg_valid && n < limit) begin
      @(negedge clk);
      n++;
    end
    seen = msg_valid;
  endtask

  task automatic drive_bus(input logic cyc, input logic [31:0] adr);
    @(posedge clk);
    bus_cyc <= cyc;
    bus_adr <= adr;
    @(negedge clk);  // cs is combinational and settled by now
  endtask

  task automatic check_msg(input logic [12:0] tid, input logic [31:0] adr, input logic [31:0] dat);
    check_val("msg_tid_o", 32'(msg_tid), 32'(tid));
    check_val("msg_adr_o", msg_adr, adr);
    check_val("msg_dat_o", msg_dat, dat);
  endtask

  // a BAR selects when every masked address bit matches it
  function automatic logic [2:0] cs_model(input logic cyc, input logic [31:0] adr);
    logic [2:0] cs;
    for (int k = 0; k < 3; k++) cs[k] = cyc && ((adr & bar_msk[k]) == (bar_m[k] & bar_msk[k]));
    return cs;
  endfunction

  // ==========================================================
  // stimulus
  // ==========================================================
  initial begin
    logic [31:0] rd, r, adr, d_dat, d_adr, seed;
    logic [12:0] d_tid;
    logic [3:0]  strb;
    logic        err, seen, quiet;
    int          n, base;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pstrb = '0;
    bus_cyc = 1'b0;
    bus_adr = '0;
    irq = '0;
    msg_ready = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    tests_bad = 0;
    seed = $urandom(32'h7fbc);  // seeds the generator once
    bar_msk = '{BAR0_MSK, BAR1_MSK, BAR2_MSK};
    bar_m   = '{BAR0_RST, BAR1_RST, BAR2_RST};

    n = 0;
    @(posedge clk);
    while (rst && n < 20) begin
      @(posedge clk);
      n++;
    end
    check_cond("reset released", !rst);
    @(negedge clk);
    check_val("pready_o after reset", 32'(pready), 32'd0);
    check_val("pslverr_o after reset", 32'(pslverr), 32'd0);
    check_val("msg_valid_o after reset", 32'(msg_valid), 32'd0);

    // identity words and unmapped offsets
    test_begin();
    apb_read(OFF_ID, rd, err);
    check_val("prdata_o id", rd, {DEV_ID, VEN_ID});
    check_val("pslverr_o id", 32'(err), 32'd0);
    apb_read(OFF_CLASS, rd, err);
    check_val("prdata_o class", rd, {CLASS, 8'h00});
    apb_read(OFF_HDR, rd, err);
    check_val("prdata_o header", rd, {24'd0, CLINE});
    apb_read(OFF_SUBSYS, rd, err);
    check_val("prdata_o subsystem", rd, {SUB_ID, SUB_VEN_ID});
    apb_read(10'd7, rd, err);
    check_val("pslverr_o unmapped", 32'(err), 32'd1);
    check_val("prdata_o unmapped", rd, 32'd0);
    apb_read(10'd100, rd, err);
    check_val("pslverr_o unmapped", 32'(err), 32'd1);
    test_end("identity and error response");

    // command register with forced and writable bits
    test_begin();
    apb_read(OFF_CMD, rd, err);
    check_val("prdata_o command after reset", 32'(rd[15:0]), 32'h0203);
    check_val("prdata_o status fixed bits", 32'(rd[31:16]), 32'(STAT_EXP));
    apb_write(OFF_CMD, 32'h0000_FFFF, 4'b0011);  // also sets int disable
    apb_read(OFF_CMD, rd, err);
    check_val("prdata_o command after all-ones", 32'(rd[15:0]), 32'h0747);
    @(posedge clk);
    irq <= 4'b0001;
    n = 0;
    apb_read(OFF_CMD, rd, err);
    while (!rd[19] && n < 5) begin
      apb_read(OFF_CMD, rd, err);
      n++;
    end
    check_val("prdata_o status with irq high", 32'(rd[31:16]), 32'(STAT_EXP | 16'h0008));
    @(posedge clk);
    irq <= 4'b0000;
    test_end("command and status");

    // BAR size probe, byte writes and chip selects
    test_begin();
    for (int k = 0; k < 3; k++) begin
      apb_write(10'(int'(OFF_BAR0) + k), 32'hFFFF_FFFF, 4'hF);
      bar_m[k] = bar_msk[k];
      apb_read(10'(int'(OFF_BAR0) + k), rd, err);
      check_val("prdata_o BAR size mask", rd, bar_m[k]);
      r    = $urandom;
      strb = 4'(($urandom % 14) + 1);  // partial strobes that never cover all four lanes
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) bar_m[k][8*b +: 8] = r[8*b +: 8];
      end
      apb_write(10'(int'(OFF_BAR0) + k), r, strb);
      apb_read(10'(int'(OFF_BAR0) + k), rd, err);
      check_val("prdata_o BAR after byte write", rd, bar_m[k]);
      adr = (bar_m[k] & bar_msk[k]) | ($urandom & ~bar_msk[k]);
      drive_bus(1'b1, adr);
      check_val("cs_bar_o on match", 32'(cs_bar), 32'(cs_model(1'b1, adr)));
      check_cond("own chip select high on match", cs_bar[k]);
      adr = adr ^ (bar_msk[k] & (~bar_msk[k] + 32'd1));  // lowest masked bit
      drive_bus(1'b1, adr);
      check_val("cs_bar_o on miss", 32'(cs_bar), 32'(cs_model(1'b1, adr)));
      check_cond("own chip select low on miss", !cs_bar[k]);
      drive_bus(1'b0, bar_m[k]);
      check_val("cs_bar_o without cycle", 32'(cs_bar), 32'd0);
    end
    test_end("base address registers");

    // software trigger on source 3 while the consumer stalls
    test_begin();
    base  = int'(OFF_IRQ_BASE) + 4 * 3;
    d_dat = $urandom;
    d_adr = $urandom;
    d_tid = 13'($urandom);
    apb_write(10'(base), d_dat, 4'hF);
    apb_write(10'(base + 1), d_adr, 4'hF);
    apb_write(10'(base + 2), {1'b1, 18'd0, d_tid}, 4'hF);
    wait_msg(40, seen);
    check_cond("software interrupt message arrived", seen);
    check_msg(d_tid, d_adr, d_dat);
    repeat (8) begin
      @(negedge clk);
      check_val("msg_valid_o while stalled", 32'(msg_valid), 32'd1);
      check_msg(d_tid, d_adr, d_dat);
    end
    @(posedge clk);
    msg_ready <= 1'b1;
    @(posedge clk);
    msg_ready <= 1'b0;
    @(negedge clk);
    check_val("msg_valid_o after pop", 32'(msg_valid), 32'd0);
    apb_read(10'(base + 2), rd, err);
    check_val("prdata_o tid word after trigger", rd, {19'd0, d_tid});  // request flag consumed
    test_end("software interrupt");

    // hardware line on source 1, then holdoff, then int disable
    test_begin();
    apb_write(OFF_CMD, 32'h0000_0003, 4'b0011);
    base  = int'(OFF_IRQ_BASE) + 4 * 1;
    d_dat = $urandom;
    d_adr = $urandom;
    d_tid = 13'($urandom);
    apb_write(10'(base), d_dat, 4'hF);
    apb_write(10'(base + 1), d_adr, 4'hF);
    apb_write(10'(base + 2), {19'd0, d_tid}, 4'hF);
    @(posedge clk);
    msg_ready <= 1'b1;
    irq       <= 4'b0010;
    wait_msg(40, seen);
    check_cond("first hardware message arrived", seen);
    check_msg(d_tid, d_adr, d_dat);
    quiet = 1'b1;
    repeat (63) begin
      @(negedge clk);
      if (msg_valid) quiet = 1'b0;
    end
    check_cond("source stays silent during holdoff", quiet);
    wait_msg(100, seen);
    check_cond("second hardware message arrived", seen);
    check_msg(d_tid, d_adr, d_dat);
    @(posedge clk);
    irq <= 4'b0000;
    apb_write(OFF_CMD, 32'h0000_0403, 4'b0011);  // int disable
    @(posedge clk);
    irq <= 4'b0100;
    quiet = 1'b1;
    repeat (100) begin
      @(negedge clk);
      if (msg_valid) quiet = 1'b0;
    end
    check_cond("disabled line sends no message", quiet);
    @(posedge clk);
    irq       <= 4'b0000;
    msg_ready <= 1'b0;
    test_end("hardware interrupt");

    $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
             tests, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* bench/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held over the first cycles, released on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* common/cfg_pkg.sv */
package cfg_pkg;

  // ==========================================================
  // register map, word offsets from paddr[11:2]
  // ==========================================================
  localparam int CFG_OFF_W = 10;

  localparam logic [CFG_OFF_W-1:0] OFF_ID       = 10'd0;   // device id, vendor id
  localparam logic [CFG_OFF_W-1:0] OFF_CMD      = 10'd1;   // status, command
  localparam logic [CFG_OFF_W-1:0] OFF_CLASS    = 10'd2;   // class code, revision
  localparam logic [CFG_OFF_W-1:0] OFF_HDR      = 10'd3;   // bist, hdr type, lat, cache line
  localparam logic [CFG_OFF_W-1:0] OFF_BAR0     = 10'd4;
  localparam logic [CFG_OFF_W-1:0] OFF_BAR1     = 10'd5;
  localparam logic [CFG_OFF_W-1:0] OFF_BAR2     = 10'd6;
  localparam logic [CFG_OFF_W-1:0] OFF_SUBSYS   = 10'd11;
  localparam logic [CFG_OFF_W-1:0] OFF_ROM      = 10'd12;  // no expansion rom, reads 0
  // four words per source: dat, adr, trigger+tid, reserved
  localparam logic [CFG_OFF_W-1:0] OFF_IRQ_BASE = 10'd16;

  // ==========================================================
  // command / status bits
  // ==========================================================
  // io, mem, master, parity resp, serr, int disable
  localparam logic [15:0] CMD_WRITABLE   = 16'h0547;
  localparam logic [15:0] CMD_FORCED_ONE = 16'h0200;  // fast b2b enable
  localparam logic [15:0] CMD_RESET      = 16'h4003;
  // 66MHz, fast b2b capable, medium devsel
  localparam logic [15:0] STAT_FIXED     = 16'h02A0;
  localparam int          CMD_INT_DISABLE = 10;

  // interrupt message payload, 77 bits
  typedef struct packed {
    logic [12:0] tid;
    logic [31:0] adr;
    logic [31:0] dat;
  } irq_msg_t;

  // holdoff timer rests at its max value
  localparam int                   HOLDOFF_W   = 6;
  localparam logic [HOLDOFF_W-1:0] HOLDOFF_MAX = 6'd63;

endpackage

/* common/cfg_reg_if.sv */
`timescale 1ns/1ps

// one decoded register access, ctrl -> bank
interface cfg_reg_if #(
  parameter int IDX_W = 3
);
  logic             sel;    // high in the first access cycle only
  logic             we;
  logic [IDX_W-1:0] idx;    // word index inside the bank
  logic [31:0]      wdata;
  logic [3:0]       strb;   // byte lanes
  logic [31:0]      rdata;  // combinational from the bank

  modport ctrl (output sel, we, idx, wdata, strb, input rdata);
  modport bank (input sel, we, idx, wdata, strb, output rdata);

endinterface

/* irq/irq_msg_table.sv */
`timescale 1ns/1ps

module irq_msg_table import cfg_pkg::*; #(
  parameter int NIRQ = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  cfg_reg_if.bank             irq_bus,
  output irq_msg_t [NIRQ-1:0] msg_tab_o,
  output logic [NIRQ-1:0]     sw_req_o,   // software trigger pending
  input  logic [NIRQ-1:0]     sw_clr_i
);

  localparam int SRC_W = (NIRQ > 1) ? $clog2(NIRQ) : 1;

  logic [SRC_W-1:0] src;
  logic [1:0]       word;
  logic             wr;

  assign src  = irq_bus.idx[SRC_W+1:2];
  assign word = irq_bus.idx[1:0];     // 0 dat, 1 adr, 2 tid, 3 reserved
  assign wr   = irq_bus.sel & irq_bus.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int n = 0; n < NIRQ; n++) begin
        msg_tab_o[n].dat <= 32'd0;
        msg_tab_o[n].adr <= 32'hFFFF_FFFF;
        msg_tab_o[n].tid <= 13'd0;
      end
      sw_req_o <= '0;
    end else begin
      sw_req_o <= sw_req_o & ~sw_clr_i;  // consumed by the trigger
      if (wr) begin
        case (word)
          2'd0: if (&irq_bus.strb) msg_tab_o[src].dat <= irq_bus.wdata;
          2'd1: if (&irq_bus.strb) msg_tab_o[src].adr <= irq_bus.wdata;
          2'd2: begin
            if (&irq_bus.strb[1:0]) msg_tab_o[src].tid <= irq_bus.wdata[12:0];
            if (irq_bus.strb[3] && irq_bus.wdata[31]) sw_req_o[src] <= 1'b1;  // set wins
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (word)
      2'd0:    irq_bus.rdata = msg_tab_o[src].dat;
      2'd1:    irq_bus.rdata = msg_tab_o[src].adr;
      2'd2:    irq_bus.rdata = {sw_req_o[src], 18'd0, msg_tab_o[src].tid};
      default: irq_bus.rdata = 32'd0;
    endcase
  end

endmodule

/* irq/irq_trigger.sv */
`timescale 1ns/1ps

module irq_trigger import cfg_pkg::*; #(
  parameter int NIRQ = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [NIRQ-1:0]     irq_i,          // async hw lines
  input  logic                int_disable_i,
  input  logic [NIRQ-1:0]     sw_req_i,
  input  irq_msg_t [NIRQ-1:0] msg_tab_i,
  output logic [NIRQ-1:0]     sw_clr_o,
  output logic                irq_any_o,
  output logic                push_o,
  output irq_msg_t            msg_o
);

  logic [NIRQ-1:0]      sync1_q, sync2_q;
  logic [NIRQ-1:0]      flag_q;                // ready to send
  logic [NIRQ-1:0]      active, pick_oh;
  logic [HOLDOFF_W-1:0] timer_q [NIRQ];
  int                   pick_idx;

  assign irq_any_o = |sync2_q;
  assign active    = (sync2_q & {NIRQ{~int_disable_i}}) | sw_req_i;
  assign pick_oh   = flag_q & (~flag_q + NIRQ'(1));  // lowest set bit
  assign sw_clr_o  = pick_oh & sw_req_i;

  always_comb begin
    pick_idx = 0;
    for (int n = NIRQ - 1; n >= 0; n--) begin
      if (flag_q[n]) pick_idx = n;
    end
  end

  // ==========================================================
  // sync, holdoff, flag
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      flag_q  <= '0;
      push_o  <= 1'b0;
      for (int n = 0; n < NIRQ; n++) timer_q[n] <= HOLDOFF_MAX;  // armed
    end else begin
      sync1_q <= irq_i;
      sync2_q <= sync1_q;
      push_o  <= |flag_q;  // one message per cycle
      for (int n = 0; n < NIRQ; n++) begin
        if (pick_oh[n]) begin
          flag_q[n]  <= 1'b0;
          timer_q[n] <= '0;   // restart holdoff
        end else begin
          if (active[n] && timer_q[n] == HOLDOFF_MAX) flag_q[n] <= 1'b1;
          if (timer_q[n] != HOLDOFF_MAX) timer_q[n] <= timer_q[n] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|flag_q) msg_o <= msg_tab_i[pick_idx];  // descriptor of the winner
  end

endmodule

/* rtl/cfg_ctrl.sv */
`timescale 1ns/1ps

module cfg_ctrl import cfg_pkg::*; #(
  parameter int          NIRQ             = 4,
  parameter logic [15:0] VENDOR_ID        = 16'h0,
  parameter logic [15:0] DEVICE_ID        = 16'h0,
  parameter logic [15:0] SUBSYS_VENDOR_ID = 16'h0,
  parameter logic [15:0] SUBSYS_ID        = 16'h0,
  parameter logic [23:0] CLASS_CODE       = 24'h0,
  parameter logic [7:0]  CACHE_LINE       = 8'd0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [11:0] paddr_i,
  input  logic [31:0] pwdata_i,
  input  logic [3:0]  pstrb_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  cfg_reg_if.ctrl     hdr_bus,
  cfg_reg_if.ctrl     irq_bus
);

  localparam int SRC_W     = (NIRQ > 1) ? $clog2(NIRQ) : 1;
  localparam int IRQ_IDX_W = SRC_W + 2;
  localparam int IRQ_END   = int'(OFF_IRQ_BASE) + 4 * NIRQ;  // first offset past the table

  typedef enum logic [1:0] {ST_IDLE, ST_ACC1, ST_ACC2} state_e;

  state_e               state_q;
  logic [CFG_OFF_W-1:0] off;
  logic                 hit_hdr, hit_irq, hit_const;
  logic [31:0]          const_word;

  assign off = paddr_i[11:2];  // word offset

  // ==========================================================
  // offset decode, the only one in the block
  // ==========================================================
  always_comb begin
    hit_hdr    = 1'b0;
    hit_irq    = 1'b0;
    hit_const  = 1'b1;
    const_word = 32'd0;
    case (off)
      OFF_ID:     const_word = {DEVICE_ID, VENDOR_ID};
      OFF_CLASS:  const_word = {CLASS_CODE, 8'h00};           // revision 0
      OFF_HDR:    const_word = {8'h00, 8'h00, 8'h00, CACHE_LINE};  // general device
      OFF_SUBSYS: const_word = {SUBSYS_ID, SUBSYS_VENDOR_ID};
      OFF_ROM:    const_word = 32'd0;
      OFF_CMD, OFF_BAR0, OFF_BAR1, OFF_BAR2: begin
        hit_const = 1'b0;
        hit_hdr   = 1'b1;
      end
      default: begin
        hit_const = 1'b0;
        hit_irq   = (off >= OFF_IRQ_BASE) && (int'(off) < IRQ_END);
      end
    endcase
  end

  // bank side, sel only in the first access cycle
  assign hdr_bus.sel   = (state_q == ST_ACC1) && hit_hdr;
  assign hdr_bus.we    = pwrite_i;
  assign hdr_bus.idx   = (off == OFF_CMD) ? 3'd0 : 3'(off - OFF_BAR0 + 1'b1);  // bar n -> n+1
  assign hdr_bus.wdata = pwdata_i;
  assign hdr_bus.strb  = pstrb_i;

  assign irq_bus.sel   = (state_q == ST_ACC1) && hit_irq;
  assign irq_bus.we    = pwrite_i;
  assign irq_bus.idx   = IRQ_IDX_W'(off - OFF_IRQ_BASE);  // src*4 + word
  assign irq_bus.wdata = pwdata_i;
  assign irq_bus.strb  = pstrb_i;

  // setup -> acc1 (data registered, write lands) -> acc2 (pready)
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o  <= (state_q == ST_ACC1);
      pslverr_o <= (state_q == ST_ACC1) && !(hit_const || hit_hdr || hit_irq);
      case (state_q)
        ST_IDLE: if (psel_i && !penable_i) state_q <= ST_ACC1;  // setup phase seen
        ST_ACC1: state_q <= ST_ACC2;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // read data, unmapped offsets fall through to 0
  always_ff @(posedge clk_i) begin
    if (state_q == ST_ACC1 && !pwrite_i) begin
      prdata_o <= hit_hdr ? hdr_bus.rdata :
                  hit_irq ? irq_bus.rdata : const_word;
    end
  end

endmodule

/* rtl/cfg_header_regs.sv */
`timescale 1ns/1ps

module cfg_header_regs import cfg_pkg::*; #(
  parameter logic [31:0] BAR0_RESET = 32'h0,
  parameter logic [31:0] BAR1_RESET = 32'h0,
  parameter logic [31:0] BAR2_RESET = 32'h0,
  parameter logic [31:0] BAR0_MASK  = 32'h0,
  parameter logic [31:0] BAR1_MASK  = 32'h0,
  parameter logic [31:0] BAR2_MASK  = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  cfg_reg_if.bank     hdr_bus,
  input  logic        irq_any_i,      // live interrupt status
  input  logic        bus_cyc_i,
  input  logic [31:0] bus_adr_i,
  output logic [2:0]  cs_bar_o,
  output logic        int_disable_o
);

  localparam logic [2:0][31:0] BAR_RST = {BAR2_RESET, BAR1_RESET, BAR0_RESET};
  localparam logic [2:0][31:0] BAR_MSK = {BAR2_MASK, BAR1_MASK, BAR0_MASK};

  logic [15:0] cmd_q;         // writable bits only
  logic [31:0] bar_q [3];
  logic [15:0] cmd_rd, stat_rd;
  logic        wr;

  assign wr = hdr_bus.sel & hdr_bus.we;

  // ==========================================================
  // command register
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_q <= CMD_RESET & CMD_WRITABLE;
    end else if (wr && hdr_bus.idx == 3'd0) begin
      if (hdr_bus.strb[0]) cmd_q[7:0]  <= hdr_bus.wdata[7:0] & CMD_WRITABLE[7:0];
      if (hdr_bus.strb[1]) cmd_q[15:8] <= hdr_bus.wdata[15:8] & CMD_WRITABLE[15:8];
      // upper lanes are status, nothing writable there
    end
  end

  assign cmd_rd        = cmd_q | CMD_FORCED_ONE;
  assign stat_rd       = STAT_FIXED | {12'd0, irq_any_i, 3'd0};  // bit 3 = int status
  assign int_disable_o = cmd_q[CMD_INT_DISABLE];

  // ==========================================================
  // base address registers and chip selects
  // ==========================================================
  for (genvar n = 0; n < 3; n++) begin : g_bar
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        bar_q[n] <= BAR_RST[n];
      end else if (wr && hdr_bus.idx == 3'(n + 1)) begin
        if (&hdr_bus.strb && hdr_bus.wdata == 32'hFFFF_FFFF) begin
          bar_q[n] <= BAR_MSK[n];  // size probe
        end else begin
          for (int b = 0; b < 4; b++) begin
            if (hdr_bus.strb[b]) bar_q[n][8*b +: 8] <= hdr_bus.wdata[8*b +: 8];
          end
        end
      end
    end

    // match only where the mask has ones
    assign cs_bar_o[n] = bus_cyc_i && (((bus_adr_i ^ bar_q[n]) & BAR_MSK[n]) == 32'd0);
  end

  always_comb begin
    case (hdr_bus.idx)
      3'd0:    hdr_bus.rdata = {stat_rd, cmd_rd};
      3'd1:    hdr_bus.rdata = bar_q[0];
      3'd2:    hdr_bus.rdata = bar_q[1];
      3'd3:    hdr_bus.rdata = bar_q[2];
      default: hdr_bus.rdata = 32'd0;
    endcase
  end

endmodule

/* rtl/cfg_space_top.sv */
`timescale 1ns/1ps

module cfg_space_top import cfg_pkg::*; #(
  parameter int          NIRQ             = 4,
  parameter int          FIFO_DEPTH       = 32,
  parameter logic [31:0] BAR0_RESET       = 32'hD000_0000,
  parameter logic [31:0] BAR1_RESET       = 32'hD100_0000,
  parameter logic [31:0] BAR2_RESET       = 32'hD200_0000,
  parameter logic [31:0] BAR0_MASK        = 32'hFFFF_0000,
  parameter logic [31:0] BAR1_MASK        = 32'hFFF0_0000,
  parameter logic [31:0] BAR2_MASK        = 32'hFFFF_F000,
  parameter logic [15:0] VENDOR_ID        = 16'hABCD,
  parameter logic [15:0] DEVICE_ID        = 16'h0031,
  parameter logic [15:0] SUBSYS_VENDOR_ID = 16'hABCD,
  parameter logic [15:0] SUBSYS_ID        = 16'h0001,
  parameter logic [23:0] CLASS_CODE       = 24'h038000,  // display, other
  parameter logic [7:0]  CACHE_LINE       = 8'd8
) (
  input  logic            clk_i,
  input  logic            rst_i,
  // apb slave
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [11:0]     paddr_i,
  input  logic [31:0]     pwdata_i,
  input  logic [3:0]      pstrb_i,
  output logic [31:0]     prdata_o,
  output logic            pready_o,
  output logic            pslverr_o,
  // bar decode
  input  logic            bus_cyc_i,
  input  logic [31:0]     bus_adr_i,
  output logic [2:0]      cs_bar_o,
  // interrupt lines and message stream
  input  logic [NIRQ-1:0] irq_i,
  output logic            msg_valid_o,
  input  logic            msg_ready_i,
  output logic [12:0]     msg_tid_o,
  output logic [31:0]     msg_adr_o,
  output logic [31:0]     msg_dat_o
);

  localparam int SRC_W     = (NIRQ > 1) ? $clog2(NIRQ) : 1;
  localparam int IRQ_IDX_W = SRC_W + 2;  // source, word

  cfg_reg_if                        hdr_bus ();
  cfg_reg_if #(.IDX_W(IRQ_IDX_W))   irq_bus ();

  logic                  int_disable;
  logic                  irq_any;
  irq_msg_t [NIRQ-1:0]   msg_tab;
  logic [NIRQ-1:0]       sw_req;
  logic [NIRQ-1:0]       sw_clr;
  logic                  push;
  irq_msg_t              msg;

  cfg_ctrl #(
    .NIRQ(NIRQ), .VENDOR_ID(VENDOR_ID), .DEVICE_ID(DEVICE_ID),
    .SUBSYS_VENDOR_ID(SUBSYS_VENDOR_ID), .SUBSYS_ID(SUBSYS_ID),
    .CLASS_CODE(CLASS_CODE), .CACHE_LINE(CACHE_LINE)
  ) u_ctrl (
    .clk_i, .rst_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i, .pstrb_i,
    .prdata_o, .pready_o, .pslverr_o, .hdr_bus(hdr_bus.ctrl), .irq_bus(irq_bus.ctrl)
  );

  cfg_header_regs #(
    .BAR0_RESET(BAR0_RESET), .BAR1_RESET(BAR1_RESET), .BAR2_RESET(BAR2_RESET),
    .BAR0_MASK(BAR0_MASK), .BAR1_MASK(BAR1_MASK), .BAR2_MASK(BAR2_MASK)
  ) u_hdr (
    .clk_i, .rst_i, .hdr_bus(hdr_bus.bank), .irq_any_i(irq_any), .bus_cyc_i,
    .bus_adr_i, .cs_bar_o, .int_disable_o(int_disable)
  );

  irq_msg_table #(.NIRQ(NIRQ)) u_tab (
    .clk_i, .rst_i, .irq_bus(irq_bus.bank), .msg_tab_o(msg_tab), .sw_req_o(sw_req),
    .sw_clr_i(sw_clr)
  );

  irq_trigger #(.NIRQ(NIRQ)) u_trig (
    .clk_i, .rst_i, .irq_i, .int_disable_i(int_disable), .sw_req_i(sw_req),
    .msg_tab_i(msg_tab), .sw_clr_o(sw_clr), .irq_any_o(irq_any), .push_o(push),
    .msg_o(msg)
  );

  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk_i, .rst_i, .push_i(push), .msg_i(msg), .msg_valid_o, .msg_ready_i,
    .msg_tid_o, .msg_adr_o, .msg_dat_o
  );

endmodule

/* rtl/msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo import cfg_pkg::*; #(
  parameter int FIFO_DEPTH = 32
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        push_i,
  input  irq_msg_t    msg_i,
  output logic        msg_valid_o,
  input  logic        msg_ready_i,
  output logic [12:0] msg_tid_o,
  output logic [31:0] msg_adr_o,
  output logic [31:0] msg_dat_o
);

  localparam int             AW       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [AW:0]    CNT_FULL = (AW + 1)'(FIFO_DEPTH);
  localparam logic [AW-1:0]  PTR_LAST = AW'(FIFO_DEPTH - 1);

  irq_msg_t      mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AW:0]   cnt_q;
  logic          wr_en, rd_en;

  assign wr_en       = push_i && (cnt_q != CNT_FULL);  // full drops the push
  assign msg_valid_o = (cnt_q != '0);
  assign rd_en       = msg_valid_o && msg_ready_i;

  // fall-through head
  assign msg_tid_o = mem[rd_ptr_q].tid;
  assign msg_adr_o = mem[rd_ptr_q].adr;
  assign msg_dat_o = mem[rd_ptr_q].dat;

  always_ff @(posedge clk_i) begin
    if (wr_en) mem[wr_ptr_q] <= msg_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      if (rd_en) rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

endmodule

/* sources.f */
common/cfg_pkg.sv
common/cfg_reg_if.sv
rtl/cfg_ctrl.sv
rtl/cfg_header_regs.sv
irq/irq_msg_table.sv
irq/irq_trigger.sv
rtl/msg_fifo.sv
rtl/cfg_space_top.sv
bench/tb_clkgen.sv
bench/tb_cfg_space.sv
